//--- Bender.yml
package:
  name: mem_ctrl

sources:
  - files:
      - verilog/memCtrlPkg.sv
      - verilog/memBusIf.sv
      - verilog/reqArbiter.sv
      - verilog/byteSequencer.sv
      - verilog/wordAssembler.sv
      - verilog/memCtrl.sv
  - target: test
    files:
      - tb/ramModel.sv
      - tb/memCtrlTb.sv

//--- list.f
verilog/memCtrlPkg.sv
verilog/memBusIf.sv
verilog/reqArbiter.sv
verilog/byteSequencer.sv
verilog/wordAssembler.sv
verilog/memCtrl.sv
tb/ramModel.sv
tb/memCtrlTb.sv

//--- tb/memCtrlTb.sv
`timescale 1ns/100ps

module memCtrlTb;

    // loads, store pairs, fetches, priority pairs, stalled mix
    localparam int numTrans      = 9 + 12 + 4 + 4 + 16;
    localparam int timeoutCycles = numTrans * 12 + 200;

    typedef struct packed {
        logic        store;
        logic [2:0]  len;
        logic [31:0] word;
        logic [31:0] start;
        logic [31:0] stalls;
        logic [31:0] writes;
    } expect_t;

    logic                   clk, rst, rdy, ioBufferFull;
    logic                   memWe, fetchEn, fetchDone, bpEn, dataEn, dataStore, dataDone;
    logic [7:0]             memDin, memDout;
    logic [31:0]            memAddr, fetchAddr, fetchInst, bpInst, dataAddr, dataIn, dataOut;
    memCtrlPkg::memLen_e    dataLen;
    memCtrlPkg::waitOwner_e dataWait, fetchWait;

    logic [7:0]             shadow [0:255];
    expect_t                dataQ[$];
    expect_t                fetchQ[$];
    int                     cycleCount = 0;
    int                     stallCount = 0;
    int                     weCount = 0;
    int                     bytesLeft = 0;
    bit                     busy = 1'b0;
    bit                     stallsOn = 1'b0;
    bit                     prevDone = 1'b0;
    memCtrlPkg::waitOwner_e ownerModel = memCtrlPkg::waitNone;
    memCtrlPkg::memLen_e    lens [3] = '{memCtrlPkg::lenByte, memCtrlPkg::lenHalf,
                                         memCtrlPkg::lenWord};

    memCtrl #(.addrWidth(32)) dut_i (.*);

    ramModel #(.addrWidth(32)) ram_i (
        .clk  (clk),
        .we   (memWe),
        .addr (memAddr),
        .din  (memDout),
        .dout (memDin)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [7:0] fillByte(input int a);
        return 8'((a * 29) ^ 8'h6c);
    endfunction

    // little endian from the shadow bytes with the upper bytes zero
    function automatic logic [31:0] expectWord(input logic [31:0] addr, input int len);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < len; i++) begin
            word[8*i +: 8] = shadow[(addr + i) % 256];
        end
        return word;
    endfunction

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkData(input string name, input logic [31:0] got, exp);
        if (got !== exp)
            stopRun($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic checkInst(input string name, input logic [31:0] got, exp);
        if (got !== exp)
            stopRun($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic checkWait(input string name, input memCtrlPkg::waitOwner_e got, exp);
        if (got !== exp)
            stopRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic checkLevel(input string name, input logic got, exp);
        if (got !== exp)
            stopRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic checkCount(input string name, input int got, exp);
        if (got != exp)
            stopRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic nextCycle();
        @(negedge clk);
        if (stallsOn) begin
            rdy          = ($urandom % 4) != 0;
            ioBufferFull = ($urandom % 5) == 0;
        end
    endtask

    task automatic issueData(input logic store, input memCtrlPkg::memLen_e len,
                             input logic [31:0] addr, input logic [31:0] data);
        expect_t e;
        e.store  = store;
        e.len    = len;
        e.word   = store ? 32'h0 : expectWord(addr, int'(len));
        e.start  = cycleCount;
        e.stalls = stallCount;
        e.writes = weCount;
        for (int i = 0; store && i < int'(len); i++) begin
            shadow[(addr + i) % 256] = data[8*i +: 8];
        end
        dataQ.push_back(e);
        dataEn    = 1'b1;
        dataStore = store;
        dataLen   = len;
        dataAddr  = addr;
        dataIn    = data;
    endtask

    task automatic issueFetch(input logic [31:0] addr);
        expect_t e;
        e        = '0;
        e.len    = 3'd4;
        e.word   = expectWord(addr, 4);
        e.start  = cycleCount;
        e.stalls = stallCount;
        fetchQ.push_back(e);
        fetchEn   = 1'b1;
        fetchAddr = addr;
    endtask

    task automatic awaitData();
        do begin
            nextCycle();
        end while (!dataDone);
        dataEn = 1'b0;
    endtask

    task automatic awaitFetch();
        do begin
            nextCycle();
        end while (!fetchDone);
        fetchEn = 1'b0;
    endtask

    // cycle count, stall count, write count and the owner model
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (memWe) begin
            weCount = weCount + 1;
        end
        if (cycleCount > timeoutCycles) begin
            stopRun($sformatf("the run did not finish within %0d clock cycles", timeoutCycles));
        end else if (rst) begin
            ownerModel = memCtrlPkg::waitNone;
            bytesLeft  = 0;
            busy       = 1'b0;
        end else if (!rdy || ioBufferFull) begin
            stallCount = stallCount + 1;
        end else if (bytesLeft != 0) begin
            bytesLeft = bytesLeft - 1;
            if (bytesLeft == 0) begin
                ownerModel = memCtrlPkg::waitNone;
            end
        end else if (!busy && (dataEn || fetchEn)) begin
            busy       = 1'b1;
            ownerModel = dataEn ? memCtrlPkg::waitData : memCtrlPkg::waitFetch;
            bytesLeft  = dataEn ? int'(dataLen) : 4;
        end
    end

    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            checkWait("dataWait", dataWait, ownerModel);
            checkWait("fetchWait", fetchWait, ownerModel);
            if (prevDone && (dataDone || fetchDone || bpEn)) begin
                stopRun("a done output stayed high for more than one cycle");
            end else if (dataDone && dataQ.size() == 0) begin
                stopRun("dataDone pulsed while no data request was waiting for it");
            end else if ((fetchDone || bpEn) && fetchQ.size() == 0) begin
                stopRun("fetchDone or bpEn pulsed while no fetch request was waiting for it");
            end else if (dataDone) begin
                e = dataQ.pop_front();
                checkLevel("fetchDone", fetchDone, 1'b0);
                checkLevel("bpEn", bpEn, 1'b0);
                checkCount("dataDone latency", cycleCount - int'(e.start),
                           int'(e.len) + 2 + stallCount - int'(e.stalls));
                if (e.store) begin
                    checkCount("memWe pulses", weCount - int'(e.writes), int'(e.len));
                end else begin
                    checkData("dataOut", dataOut, e.word);
                end
                busy = 1'b0;
            end else if (fetchDone || bpEn) begin
                e = fetchQ.pop_front();
                checkLevel("fetchDone", fetchDone, 1'b1);
                checkLevel("bpEn", bpEn, 1'b1);
                checkCount("fetchDone latency", cycleCount - int'(e.start),
                           int'(e.len) + 2 + stallCount - int'(e.stalls));
                checkInst("fetchInst", fetchInst, e.word);
                checkInst("bpInst", bpInst, e.word);
                busy = 1'b0;
            end
            prevDone = dataDone || fetchDone || bpEn;
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] word;
        int          kind;
        void'($urandom(60));
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = memCtrlPkg::lenByte;
        dataAddr     = '0;
        dataIn       = '0;
        for (int a = 0; a < 256; a++) begin
            shadow[a]    = fillByte(a);
            ram_i.mem[a] = fillByte(a);
        end
        repeat (16) nextCycle();
        rst = 1'b0;
        nextCycle();
        checkLevel("memWe", memWe, 1'b0);
        checkLevel("dataDone", dataDone, 1'b0);
        checkLevel("fetchDone", fetchDone, 1'b0);
        checkLevel("bpEn", bpEn, 1'b0);
        checkWait("dataWait", dataWait, memCtrlPkg::waitNone);
        checkWait("fetchWait", fetchWait, memCtrlPkg::waitNone);

        for (int k = 0; k < 9; k++) begin
            addr = $urandom % 256;
            issueData(1'b0, lens[k / 3], addr, '0);
            awaitData();
        end

        // every store is read back as a whole word
        for (int k = 0; k < 6; k++) begin
            addr = $urandom % 256;
            word = $urandom;
            issueData(1'b1, lens[k / 2], addr, word);
            awaitData();
            issueData(1'b0, memCtrlPkg::lenWord, addr, '0);
            awaitData();
        end

        for (int n = 0; n < 4; n++) begin
            issueFetch($urandom % 256);
            awaitFetch();
        end

        // both enables in one cycle so the fetch waits for the data done
        for (int n = 0; n < 2; n++) begin
            addr = $urandom % 256;
            word = $urandom % 256;
            issueData(1'b0, memCtrlPkg::lenWord, addr, '0);
            fetchEn   = 1'b1;
            fetchAddr = word;
            awaitData();
            issueFetch(word);
            awaitFetch();
        end

        stallsOn = 1'b1;
        for (int n = 0; n < 16; n++) begin
            kind = $urandom % 3;
            addr = $urandom % 256;
            word = $urandom;
            if (kind == 2) begin
                issueFetch(addr);
                awaitFetch();
            end else begin
                issueData(kind == 1, lens[$urandom % 3], addr, word);
                awaitData();
            end
        end
        stallsOn     = 1'b0;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        repeat (3) nextCycle();

        if (dataQ.size() != 0 || fetchQ.size() != 0) begin
            stopRun("some requests never received their done pulse");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- tb/ramModel.sv
`timescale 1ns/100ps

// byte ram, read data one cycle after the address
module ramModel #(
    parameter int addrWidth = 32
) (
    input  logic                             clk,
    input  logic                             we,
    input  logic [addrWidth-1:0]             addr,
    input  logic [memCtrlPkg::byteWidth-1:0] din,
    output logic [memCtrlPkg::byteWidth-1:0] dout
);

    // 256 bytes, upper address bits ignored
    logic [memCtrlPkg::byteWidth-1:0] mem [0:255];

    always @(posedge clk) begin
        if (we) begin
            mem[addr[7:0]] <= din;
        end
        dout <= mem[addr[7:0]];
    end

endmodule

//--- verilog/byteSequencer.sv
`timescale 1ns/100ps

module byteSequencer #(
    parameter int addrWidth = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             active,
    memReqIf.sequencer                       req,
    memByteIf.source                         bytes,
    output logic                             memWe,
    output logic [addrWidth-1:0]             memAddr,
    output logic [memCtrlPkg::byteWidth-1:0] memDout
);

    typedef enum logic {
        seqIdle,
        seqRun
    } seq_e;

    seq_e                 state;
    logic [1:0]           stage;
    logic                 granted;
    logic                 issue;
    logic                 lastByte;
    logic [addrWidth-1:0] heldAddr;

    assign granted  = req.op != memCtrlPkg::opNone;
    assign issue    = active && granted;
    assign lastByte = ({1'b0, stage} + 3'd1) == req.len;

    assign req.releaseGrant = issue && lastByte;

    // a stalled cycle repeats the previous address
    // so the read byte in flight is still there after the stall
    assign memAddr = active ? req.addr + addrWidth'(stage) : heldAddr;
    assign memWe   = issue && (req.op == memCtrlPkg::opStore);
    assign memDout = req.storeData[stage * memCtrlPkg::byteWidth +: memCtrlPkg::byteWidth];

    assign bytes.issued = issue;
    assign bytes.index  = stage;
    assign bytes.last   = lastByte;
    assign bytes.op     = req.op;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            stage <= 2'd0;
        end else if (issue) begin
            if (lastByte) begin
                state <= seqIdle;
                stage <= 2'd0;
            end else begin
                state <= seqRun;
                stage <= stage + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            heldAddr <= memAddr;
        end
    end

    // writes only inside a store grant
    storeOnlyWrite: assert property (@(posedge clk) disable iff (rst)
        memWe |-> (req.op == memCtrlPkg::opStore));

    stageInRange: assert property (@(posedge clk) disable iff (rst)
        granted |-> ({1'b0, stage} < req.len));

    // mid-transaction means the grant is still held
    runHoldsGrant: assert property (@(posedge clk) disable iff (rst)
        (state == seqRun) |-> granted);

endmodule

//--- verilog/memBusIf.sv
`timescale 1ns/100ps

// locked grant, arbiter to sequencer
interface memReqIf #(
    parameter int addrWidth = 32
) ();

    memCtrlPkg::memOp_e              op;
    logic [addrWidth-1:0]            addr;
    memCtrlPkg::memLen_e             len;
    logic [memCtrlPkg::wordWidth-1:0] storeData;
    // pulses with the last byte cycle
    logic                            releaseGrant;

    modport arbiter (
        output op,
        output addr,
        output len,
        output storeData,
        input  releaseGrant
    );

    modport sequencer (
        input  op,
        input  addr,
        input  len,
        input  storeData,
        output releaseGrant
    );

endinterface

// per-byte status, sequencer to assembler
interface memByteIf ();

    logic               issued;
    logic [1:0]         index;
    logic               last;
    memCtrlPkg::memOp_e op;

    modport source (
        output issued,
        output index,
        output last,
        output op
    );

    modport sink (
        input issued,
        input index,
        input last,
        input op
    );

endinterface

//--- verilog/memCtrl.sv
`timescale 1ns/100ps

module memCtrl #(
    parameter int addrWidth = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rdy,
    input  logic                             ioBufferFull,

    input  logic [memCtrlPkg::byteWidth-1:0] memDin,
    output logic                             memWe,
    output logic [addrWidth-1:0]             memAddr,
    output logic [memCtrlPkg::byteWidth-1:0] memDout,

    input  logic                             fetchEn,
    input  logic [addrWidth-1:0]             fetchAddr,
    output logic                             fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0] fetchInst,
    output memCtrlPkg::waitOwner_e           fetchWait,

    output logic                             bpEn,
    output logic [memCtrlPkg::wordWidth-1:0] bpInst,

    input  logic                             dataEn,
    input  logic                             dataStore,
    input  memCtrlPkg::memLen_e              dataLen,
    input  logic [addrWidth-1:0]             dataAddr,
    input  logic [memCtrlPkg::wordWidth-1:0] dataIn,
    output logic                             dataDone,
    output logic [memCtrlPkg::wordWidth-1:0] dataOut,
    output memCtrlPkg::waitOwner_e           dataWait
);

    // one stall level for all stages
    logic active;

    assign active = rdy && !ioBufferFull;

    memReqIf #(.addrWidth(addrWidth)) reqBus ();
    memByteIf byteBus ();

    reqArbiter #(.addrWidth(addrWidth)) arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .active    (active),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataIn    (dataIn),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .req       (reqBus.arbiter),
        .dataWait  (dataWait),
        .fetchWait (fetchWait)
    );

    byteSequencer #(.addrWidth(addrWidth)) sequencer_i (
        .clk     (clk),
        .rst     (rst),
        .active  (active),
        .req     (reqBus.sequencer),
        .bytes   (byteBus.source),
        .memWe   (memWe),
        .memAddr (memAddr),
        .memDout (memDout)
    );

    wordAssembler assembler_i (
        .clk       (clk),
        .rst       (rst),
        .active    (active),
        .bytes     (byteBus.sink),
        .memDin    (memDin),
        .dataDone  (dataDone),
        .dataOut   (dataOut),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .bpEn      (bpEn),
        .bpInst    (bpInst)
    );

endmodule

//--- verilog/memCtrlPkg.sv
package memCtrlPkg;

    // ram is one byte wide, client words are four bytes
    localparam int byteWidth = 8;
    localparam int wordWidth = 4 * byteWidth;

    // kind of the transaction that currently owns memory
    typedef enum logic [1:0] {
        opNone  = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2,
        opFetch = 2'd3
    } memOp_e;

    // access length, value is the byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } memLen_e;

    // owner code shown to both clients
    typedef enum logic [1:0] {
        waitNone  = 2'b00,
        waitData  = 2'b01,
        waitFetch = 2'b10
    } waitOwner_e;

endpackage

//--- verilog/reqArbiter.sv
`timescale 1ns/100ps

module reqArbiter #(
    parameter int addrWidth = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             active,
    input  logic                             dataEn,
    input  logic                             dataStore,
    input  memCtrlPkg::memLen_e              dataLen,
    input  logic [addrWidth-1:0]             dataAddr,
    input  logic [memCtrlPkg::wordWidth-1:0] dataIn,
    input  logic                             fetchEn,
    input  logic [addrWidth-1:0]             fetchAddr,
    memReqIf.arbiter                         req,
    output memCtrlPkg::waitOwner_e           dataWait,
    output memCtrlPkg::waitOwner_e           fetchWait
);

    memCtrlPkg::memOp_e     nextOp;
    memCtrlPkg::waitOwner_e owner;
    // one cycle gap after release, the done cycle comes first
    logic                   settle;
    logic                   idle;

    assign idle = (req.op == memCtrlPkg::opNone) && !settle;

    // data wins over fetch
    always_comb begin
        nextOp = memCtrlPkg::opNone;
        if (dataEn) begin
            nextOp = dataStore ? memCtrlPkg::opStore : memCtrlPkg::opLoad;
        end else if (fetchEn) begin
            nextOp = memCtrlPkg::opFetch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req.op <= memCtrlPkg::opNone;
            settle <= 1'b0;
        end else if (active) begin
            if (req.releaseGrant) begin
                req.op <= memCtrlPkg::opNone;
                settle <= 1'b1;
            end else if (idle) begin
                req.op <= nextOp;
            end else begin
                settle <= 1'b0;
            end
        end
    end

    // grant payload, only loaded while idle
    always_ff @(posedge clk) begin
        if (active && idle) begin
            req.addr      <= dataEn ? dataAddr : fetchAddr;
            req.len       <= dataEn ? dataLen : memCtrlPkg::lenWord;
            req.storeData <= dataIn;
        end
    end

    always_comb begin
        case (req.op)
            memCtrlPkg::opLoad,
            memCtrlPkg::opStore: owner = memCtrlPkg::waitData;
            memCtrlPkg::opFetch: owner = memCtrlPkg::waitFetch;
            default:             owner = memCtrlPkg::waitNone;
        endcase
    end

    assign dataWait  = owner;
    assign fetchWait = owner;

    grantStable: assert property (@(posedge clk) disable iff (rst)
        (req.op != memCtrlPkg::opNone && !req.releaseGrant)
        |=> ($stable(req.op) && $stable(req.addr) && $stable(req.len)
            && $stable(req.storeData)));

    // requester keeps its enable until done
    dataEnHeld: assert property (@(posedge clk) disable iff (rst)
        (req.op inside {memCtrlPkg::opLoad, memCtrlPkg::opStore}) |-> dataEn);

endmodule

//--- verilog/wordAssembler.sv
`timescale 1ns/100ps

module wordAssembler (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             active,
    memByteIf.sink                           bytes,
    input  logic [memCtrlPkg::byteWidth-1:0] memDin,
    output logic                             dataDone,
    output logic [memCtrlPkg::wordWidth-1:0] dataOut,
    output logic                             fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0] fetchInst,
    output logic                             bpEn,
    output logic [memCtrlPkg::wordWidth-1:0] bpInst
);

    logic                             dIssued;
    logic                             dLast;
    logic [1:0]                       dIndex;
    memCtrlPkg::memOp_e               dOp;
    logic [memCtrlPkg::wordWidth-1:0] pending;
    logic [memCtrlPkg::wordWidth-1:0] merged;
    logic                             finish;

    // byte status delayed to line up with the ram read data
    always_ff @(posedge clk) begin
        if (rst) begin
            dIssued <= 1'b0;
            dLast   <= 1'b0;
            dOp     <= memCtrlPkg::opNone;
        end else if (active) begin
            dIssued <= bytes.issued;
            dLast   <= bytes.last;
            dOp     <= bytes.op;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            dIndex <= bytes.index;
        end
    end

    // byte 0 starts from zero, upper bytes stay clear for short loads
    always_comb begin
        merged = (dIndex == 2'd0) ? '0 : pending;
        merged[dIndex * memCtrlPkg::byteWidth +: memCtrlPkg::byteWidth] = memDin;
    end

    assign finish = active && dIssued && dLast;

    always_ff @(posedge clk) begin
        if (active && dIssued && dOp != memCtrlPkg::opStore) begin
            if (!dLast) begin
                pending <= merged;
            end else if (dOp == memCtrlPkg::opFetch) begin
                fetchInst <= merged;
            end else begin
                dataOut <= merged;
            end
        end
    end

    // store done needs no read data
    always_ff @(posedge clk) begin
        if (rst) begin
            dataDone  <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            dataDone  <= finish && (dOp != memCtrlPkg::opFetch);
            fetchDone <= finish && (dOp == memCtrlPkg::opFetch);
        end
    end

    // predictor sees every fetched word
    assign bpEn   = fetchDone;
    assign bpInst = fetchInst;

    oneClientDone: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone));

    donePulse: assert property (@(posedge clk) disable iff (rst)
        (dataDone || fetchDone) |=> !(dataDone || fetchDone));

endmodule
